// ==== common/ti_adc_pkg.sv ====
package ti_adc_pkg;

    // core sizes
    localparam int NTI   = 4;   // interleaved slices
    localparam int NADC  = 7;   // magnitude bits
    localparam int WB_AW = 3;   // word address bits
    localparam int WB_DW = 16;

    typedef logic signed [7:0] sample_t;   // input sample code
    typedef logic signed [7:0] offset_t;   // per-slice trim
    typedef logic signed [8:0] diff_t;     // sample minus trim, full range
    typedef logic [NADC-1:0]   mag_t;
    typedef logic [1:0]        slot_t;
    typedef logic [15:0]       frame_cnt_t;
    typedef logic [WB_AW-1:0]  wb_adr_t;
    typedef logic [WB_DW-1:0]  wb_dat_t;

    // full-scale magnitude
    localparam mag_t MAG_MAX = '1;

    // distributor to slice
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } slice_in_t;

    // slice to assembler
    typedef struct packed {
        logic valid;
        logic sign;   // 1 when sample >= offset
        mag_t mag;
    } slice_out_t;

    // register map
    localparam wb_adr_t REG_CTRL     = 3'd0;
    localparam wb_adr_t REG_OFS_BASE = 3'd1;   // one word per slice
    localparam wb_adr_t REG_FRAMES   = 3'd5;

endpackage

// ==== rtl/wb_cfg_regs.sv ====
`timescale 1ns/1ps

module wb_cfg_regs (
    input  logic                                      clk_adc,
    input  logic                                      rst_i,
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  ti_adc_pkg::wb_adr_t                       wb_adr_i,
    input  ti_adc_pkg::wb_dat_t                       wb_dat_i,
    output ti_adc_pkg::wb_dat_t                       wb_dat_o,
    output logic                                      wb_ack_o,
    input  logic                                      frame_valid_i,
    output logic                                      core_en_o,
    output logic [ti_adc_pkg::NTI-1:0]                slice_en_o,
    output ti_adc_pkg::offset_t [ti_adc_pkg::NTI-1:0] slice_ofs_o
);
    import ti_adc_pkg::*;

    logic       wb_req;
    frame_cnt_t frame_cnt;
    wb_dat_t    rd_data;

    // new request only while no ack is out
    assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            wb_ack_o    <= 1'b0;
            core_en_o   <= 1'b0;
            slice_en_o  <= '1;   // all slices on
            slice_ofs_o <= '0;
        end else begin
            wb_ack_o <= wb_req;
            if (wb_req && wb_we_i) begin
                if (wb_adr_i == REG_CTRL) begin
                    core_en_o  <= wb_dat_i[0];
                    slice_en_o <= wb_dat_i[NTI:1];
                end
                for (int k = 0; k < NTI; k++) begin
                    if (wb_adr_i == wb_adr_t'(REG_OFS_BASE + k)) begin
                        slice_ofs_o[k] <= offset_t'(wb_dat_i[7:0]);
                    end
                end
            end
        end
    end

    // completed frames, wraps
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            frame_cnt <= '0;
        end else if (frame_valid_i) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // read mux, unmapped words stay zero
    always_comb begin
        rd_data = '0;
        if (wb_adr_i == REG_CTRL) begin
            rd_data = wb_dat_t'({slice_en_o, core_en_o});
        end
        if (wb_adr_i == REG_FRAMES) begin
            rd_data = wb_dat_t'(frame_cnt);
        end
        for (int k = 0; k < NTI; k++) begin
            if (wb_adr_i == wb_adr_t'(REG_OFS_BASE + k)) begin
                rd_data = wb_dat_t'({slice_ofs_o[k]});   // zero extended
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (wb_req) begin
            wb_dat_o <= rd_data;   // valid with ack
        end
    end

endmodule

// ==== rtl/sample_distributor.sv ====
`timescale 1ns/1ps

module sample_distributor (
    input  logic                                        clk_adc,
    input  logic                                        rst_i,
    input  logic                                        core_en_i,
    input  ti_adc_pkg::sample_t                         rx_sample_i,
    input  logic                                        rx_valid_i,
    output ti_adc_pkg::slice_in_t [ti_adc_pkg::NTI-1:0] slice_in_o
);
    import ti_adc_pkg::*;

    slot_t          slot_q;     // next slice to feed
    logic           accept;
    logic [NTI-1:0] valid_q;    // one-hot or zero
    sample_t        sample_q;

    // no back-pressure, dropped while disabled
    assign accept = core_en_i & rx_valid_i;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            slot_q  <= '0;
            valid_q <= '0;
        end else begin
            valid_q <= '0;
            if (!core_en_i) begin
                slot_q <= '0;
            end else if (rx_valid_i) begin
                valid_q[slot_q] <= 1'b1;
                slot_q <= (slot_q == slot_t'(NTI - 1)) ? '0 : slot_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (accept) begin
            sample_q <= rx_sample_i;
        end
    end

    // only the addressed slice sees valid
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            slice_in_o[k].valid  = valid_q[k];
            slice_in_o[k].sample = sample_q;
        end
    end

endmodule

// ==== adc_slice/adc_slice.sv ====
`timescale 1ns/1ps

module adc_slice (
    input  logic                   clk_adc,
    input  logic                   rst_i,
    input  logic                   en_slice_i,
    input  ti_adc_pkg::offset_t    ofs_i,
    input  ti_adc_pkg::slice_in_t  slice_in_i,
    output ti_adc_pkg::slice_out_t slice_out_o
);
    import ti_adc_pkg::*;

    diff_t                     diff;
    logic [$bits(diff_t)-1:0]  abs_diff;
    logic                      sign_next;
    mag_t                      mag_next;
    logic                      valid_q;
    logic                      sign_q;
    mag_t                      mag_q;

    // offset trim, sign extended to 9 bits
    assign diff = diff_t'(slice_in_i.sample) - diff_t'(ofs_i);

    always_comb begin
        sign_next = ~diff[$bits(diff_t)-1];      // zero counts as positive
        abs_diff  = diff[$bits(diff_t)-1] ? -diff : diff;
        if (|abs_diff[$bits(diff_t)-1:NADC]) begin
            mag_next = MAG_MAX;                  // clip at full scale
        end else begin
            mag_next = abs_diff[NADC-1:0];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= slice_in_i.valid;
        end
    end

    // disabled slice still answers so frames complete
    always_ff @(posedge clk_adc) begin
        if (slice_in_i.valid) begin
            sign_q <= en_slice_i & sign_next;
            mag_q  <= en_slice_i ? mag_next : '0;
        end
    end

    assign slice_out_o = '{valid: valid_q, sign: sign_q, mag: mag_q};

endmodule

// ==== rtl/frame_assembler.sv ====
`timescale 1ns/1ps

module frame_assembler (
    input  logic                                         clk_adc,
    input  logic                                         rst_i,
    input  ti_adc_pkg::slice_out_t [ti_adc_pkg::NTI-1:0] slice_out_i,
    output ti_adc_pkg::mag_t [ti_adc_pkg::NTI-1:0]       adder_out_o,
    output logic [ti_adc_pkg::NTI-1:0]                   sign_out_o,
    output logic                                         frame_valid_o
);
    import ti_adc_pkg::*;

    mag_t [NTI-1:0] mag_q;       // slot storage for the frame in progress
    logic [NTI-1:0] sign_q;
    mag_t [NTI-1:0] mag_next;
    logic [NTI-1:0] sign_next;
    logic           frame_done;

    // last slot closes the frame
    assign frame_done = slice_out_i[NTI-1].valid;

    // stored slots merged with this cycle's results
    always_comb begin
        for (int k = 0; k < NTI; k++) begin
            if (slice_out_i[k].valid) begin
                mag_next[k]  = slice_out_i[k].mag;
                sign_next[k] = slice_out_i[k].sign;
            end else begin
                mag_next[k]  = mag_q[k];
                sign_next[k] = sign_q[k];
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        mag_q  <= mag_next;
        sign_q <= sign_next;
    end

    // output frame held until the next one
    always_ff @(posedge clk_adc) begin
        if (frame_done) begin
            adder_out_o <= mag_next;
            sign_out_o  <= sign_next;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= frame_done;   // single cycle
        end
    end

endmodule

// ==== rtl/ti_adc_core.sv ====
`timescale 1ns/1ps

module ti_adc_core (
    input  logic                                   clk_adc,
    input  logic                                   rst_i,
    input  ti_adc_pkg::sample_t                    rx_sample_i,
    input  logic                                   rx_valid_i,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  ti_adc_pkg::wb_adr_t                    wb_adr_i,
    input  ti_adc_pkg::wb_dat_t                    wb_dat_i,
    output ti_adc_pkg::wb_dat_t                    wb_dat_o,
    output logic                                   wb_ack_o,
    output ti_adc_pkg::mag_t [ti_adc_pkg::NTI-1:0] adder_out_o,
    output logic [ti_adc_pkg::NTI-1:0]             sign_out_o,
    output logic                                   frame_valid_o
);
    import ti_adc_pkg::*;

    logic                  core_en;
    logic [NTI-1:0]        slice_en;
    offset_t [NTI-1:0]     slice_ofs;
    slice_in_t [NTI-1:0]   slice_in;
    slice_out_t [NTI-1:0]  slice_out;

    // control and status registers
    wb_cfg_regs u_regs (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .frame_valid_i (frame_valid_o),
        .core_en_o     (core_en),
        .slice_en_o    (slice_en),
        .slice_ofs_o   (slice_ofs)
    );

    sample_distributor u_dist (   // first-level sampler
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .core_en_i   (core_en),
        .rx_sample_i (rx_sample_i),
        .rx_valid_i  (rx_valid_i),
        .slice_in_o  (slice_in)
    );

    // interleaved conversion slices
    for (genvar k = 0; k < NTI; k++) begin : iADC
        adc_slice iADC (
            .clk_adc     (clk_adc),
            .rst_i       (rst_i),
            .en_slice_i  (slice_en[k]),
            .ofs_i       (slice_ofs[k]),
            .slice_in_i  (slice_in[k]),
            .slice_out_o (slice_out[k])
        );
    end

    frame_assembler u_asm (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .slice_out_i   (slice_out),
        .adder_out_o   (adder_out_o),
        .sign_out_o    (sign_out_o),
        .frame_valid_o (frame_valid_o)
    );

endmodule

// ==== verif/tb_ti_adc_core.sv ====
`timescale 1ns/1ps

module tb_ti_adc_core;
    import ti_adc_pkg::*;

    localparam int CLK_HALF  = 2;   // 4 ns clock
    localparam int BURST_LEN = 48;
    localparam int MASK_LEN  = 32;
    localparam int PART_LEN  = 6;   // one frame plus two stray samples
    localparam int DROP_LEN  = 8;
    localparam int TAIL_LEN  = 16;
    localparam int N_SAMPLES = 2 * BURST_LEN + MASK_LEN + PART_LEN + DROP_LEN + TAIL_LEN;
    localparam int N_REG_ACC = 24;
    localparam int WATCHDOG_CYCLES = N_SAMPLES + 200 * N_REG_ACC + 1000;

    typedef struct packed {
        mag_t [NTI-1:0] mag;
        logic [NTI-1:0] sign;
    } frame_t;

    logic                clk_adc;
    logic                rst_i;
    sample_t             rx_sample_i;
    logic                rx_valid_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    wb_adr_t             wb_adr_i;
    wb_dat_t             wb_dat_i;
    wb_dat_t             wb_dat_o;
    logic                wb_ack_o;
    mag_t [NTI-1:0]      adder_out_o;
    logic [NTI-1:0]      sign_out_o;
    logic                frame_valid_o;

    // reference model state
    logic                m_en;
    logic [NTI-1:0]      m_mask;
    offset_t             m_ofs [NTI];
    int                  m_slot;
    frame_t              cur_frame;
    frame_t              exp_q [$];

    logic [31:0]         lfsr_q;
    int                  value_errors;
    int                  other_errors;
    int                  n_access;
    int                  acks_seen;
    frame_cnt_t          frames_seen;

    ti_adc_core dut_i (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .rx_sample_i   (rx_sample_i),
        .rx_valid_i    (rx_valid_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .adder_out_o   (adder_out_o),
        .sign_out_o    (sign_out_o),
        .frame_valid_o (frame_valid_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(CLK_HALF) clk_adc = ~clk_adc;
    end

    // taps 32 22 2 1 stepped once per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic void model_convert(input sample_t s, input offset_t o, input logic en,
                                          output logic sign, output mag_t mag);
        int d;
        d    = int'(s) - int'(o);
        sign = en && (d >= 0);
        if (d < 0) begin
            d = -d;
        end
        if (d > 127) begin
            d = 127;   // full scale
        end
        mag = en ? mag_t'(d) : '0;
    endfunction

    function automatic wb_dat_t expected_reg(input wb_adr_t adr);
        wb_dat_t d;
        d = '0;
        if (adr == REG_CTRL) begin
            d = wb_dat_t'({m_mask, m_en});
        end else if (adr >= REG_OFS_BASE && adr < REG_OFS_BASE + NTI) begin
            d = {8'h00, m_ofs[adr - REG_OFS_BASE]};
        end
        return d;
    endfunction

    task automatic check_mag(input string name, input mag_t exp, input mag_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_sign(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_frames(input string name, input frame_cnt_t exp, input frame_cnt_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %0t %s: expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (exp !== act) begin
            value_errors++;
            $display("FAILED %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // one classic cycle held until ack
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        @(posedge clk_adc);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(posedge clk_adc);
        #1;
        while (!wb_ack_o) begin
            @(posedge clk_adc);
            #1;
        end
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        n_access++;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        bus_cycle(1'b1, adr, dat, unused);
        if (adr == REG_CTRL) begin
            m_en   = dat[0];
            m_mask = dat[NTI:1];
            if (!dat[0]) begin
                m_slot = 0;   // pointer parks at slot 0
            end
        end else if (adr >= REG_OFS_BASE && adr < REG_OFS_BASE + NTI) begin
            m_ofs[adr - REG_OFS_BASE] = dat[7:0];
        end
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic read_check(input wb_adr_t adr);
        wb_dat_t got;
        wb_read(adr, got);
        if (adr == REG_FRAMES) begin
            check_frames("wb_dat_o (REG_FRAMES)", frames_seen, got[15:0]);
        end else begin
            check_word($sformatf("wb_dat_o at address %0d", adr), expected_reg(adr), got);
        end
    endtask

    task automatic send_sample(input logic v, input sample_t s);
        logic sgn;
        mag_t mg;
        @(posedge clk_adc);
        #1;
        rx_valid_i  = v;
        rx_sample_i = s;
        if (v && m_en) begin
            model_convert(s, m_ofs[m_slot], m_mask[m_slot], sgn, mg);
            cur_frame.mag[m_slot]  = mg;
            cur_frame.sign[m_slot] = sgn;
            if (m_slot == NTI - 1) begin
                exp_q.push_back(cur_frame);
                m_slot = 0;
            end else begin
                m_slot++;
            end
        end
    endtask

    task automatic run_burst(input int n, input logic extremes);
        logic [31:0] r;
        sample_t     s;
        for (int i = 0; i < n; i++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'b00) begin
                send_sample(1'b0, '0);   // random gap
            end
            r = rand_bits(8);
            s = r[7:0];
            if (extremes && i % 5 == 0) begin
                s = (i % 10 == 0) ? 8'h80 : 8'h7f;
            end
            send_sample(1'b1, s);
        end
        send_sample(1'b0, '0);
        repeat (8) @(posedge clk_adc);   // let the pipeline drain
    endtask

    always @(negedge clk_adc) begin
        frame_t f;
        if (!rst_i) begin
            if (wb_ack_o) begin
                acks_seen++;
            end
            if (frame_valid_o) begin
                frames_seen++;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("%0t: frame_valid_o raised while no frame was expected", $time);
                end else begin
                    f = exp_q.pop_front();
                    for (int k = 0; k < NTI; k++) begin
                        check_mag($sformatf("adder_out_o[%0d]", k), f.mag[k], adder_out_o[k]);
                        check_sign($sformatf("sign_out_o[%0d]", k), f.sign[k], sign_out_o[k]);
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        lfsr_q       = 32'hc031add6;
        value_errors = 0;
        other_errors = 0;
        n_access     = 0;
        acks_seen    = 0;
        frames_seen  = '0;
        m_en         = 1'b0;
        m_mask       = '1;
        m_slot       = 0;
        cur_frame    = '0;
        for (int k = 0; k < NTI; k++) begin
            m_ofs[k] = '0;
        end
        rst_i       = 1'b1;
        rx_sample_i = '0;
        rx_valid_i  = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        repeat (5) @(posedge clk_adc);
        #1;
        rst_i = 1'b0;

        // register readback with junk in the unused upper bits
        wb_write(REG_CTRL, 16'hffd5);
        read_check(REG_CTRL);
        for (int k = 0; k < NTI; k++) begin
            r = rand_bits(16);
            wb_write(wb_adr_t'(REG_OFS_BASE + k), r[15:0]);
        end
        for (int k = 0; k < NTI; k++) begin
            read_check(wb_adr_t'(REG_OFS_BASE + k));
        end
        wb_write(REG_FRAMES, 16'hbeef);
        read_check(REG_FRAMES);
        read_check(3'd6);
        read_check(3'd7);

        // random offsets and then extreme ones
        wb_write(REG_CTRL, 16'h001f);
        run_burst(BURST_LEN, 1'b1);
        wb_write(REG_OFS_BASE, 16'h007f);
        wb_write(wb_adr_t'(REG_OFS_BASE + 1), 16'h0080);
        wb_write(wb_adr_t'(REG_OFS_BASE + 2), 16'h0064);
        wb_write(wb_adr_t'(REG_OFS_BASE + 3), 16'h009c);
        run_burst(BURST_LEN, 1'b1);

        wb_write(REG_CTRL, 16'h000b);   // slices 1 and 3 masked
        run_burst(MASK_LEN, 1'b0);

        // stop mid-frame and drop samples so the restart lands on slot 0
        wb_write(REG_CTRL, 16'h001f);
        run_burst(PART_LEN, 1'b0);
        wb_write(REG_CTRL, 16'h001e);
        run_burst(DROP_LEN, 1'b0);
        wb_write(REG_CTRL, 16'h001f);
        run_burst(TAIL_LEN, 1'b0);
        read_check(REG_FRAMES);

        repeat (2) @(posedge clk_adc);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected frames were never shown", exp_q.size());
        end
        if (acks_seen != n_access) begin
            other_errors++;
            $display("saw %0d acks for %0d bus accesses", acks_seen, n_access);
        end
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
common/ti_adc_pkg.sv
rtl/wb_cfg_regs.sv
rtl/sample_distributor.sv
adc_slice/adc_slice.sv
rtl/frame_assembler.sv
rtl/ti_adc_core.sv
verif/tb_ti_adc_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ti_adc_core
DUT_TOP   ?= ti_adc_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) common/ti_adc_pkg.sv \
		$(filter rtl/% adc_slice/%,$(shell cat $(FILELIST))) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
